// ==== all.f ====
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/decode_if.sv
source/instr_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/load_store_unit.sv
source/rv_core.sv
bench/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;

  localparam int mem_words = 256;
  localparam int max_prog = 160;
  localparam int n_tests = 6;
  // reset, longest program, hold after halt and slack
  localparam int test_cycles = 4 + max_prog + 16;
  // every checked store goes to the word at this address
  localparam logic [11:0] store_base = 12'h100;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 rst_d = 1'b0;
  logic                 halt;
  rv_core_pkg::word_t   pc;
  rv_core_pkg::word_t   insn;
  rv_core_pkg::word_t   dmem_addr;
  rv_core_pkg::word_t   dmem_rdata;
  rv_core_pkg::word_t   dmem_wdata;
  rv_core_pkg::strobe_t dmem_we;

  rv_core_pkg::word_t   imem [mem_words];
  rv_core_pkg::word_t   dmem [mem_words];
  // check kind per instruction slot is 1 for a store, 2 for the next pc and 3 for halt
  logic [1:0]           exp_kind [mem_words];
  rv_core_pkg::word_t   exp_val [mem_words];
  rv_core_pkg::strobe_t exp_we [mem_words];

  logic [7:0]           slot;
  logic [1:0]           cur_kind;
  rv_core_pkg::word_t   cur_val;
  rv_core_pkg::strobe_t cur_we;
  rv_core_pkg::word_t   cur_mask;

  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    wp = 0;
  string cur_name = "reset";

  always #2 clk = ~clk;

  rv_core i_dut (
    .clk        (clk),
    .rst        (rst),
    .halt       (halt),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we)
  );

  assign slot       = pc[9:2];
  assign insn       = rst ? '0 : imem[slot];
  assign dmem_rdata = dmem[dmem_addr[9:2]];
  assign cur_kind   = exp_kind[slot];
  assign cur_val    = exp_val[slot];
  assign cur_we     = exp_we[slot];
  assign cur_mask   = {{8{cur_we[3]}}, {8{cur_we[2]}}, {8{cur_we[1]}}, {8{cur_we[0]}}};

  always @(posedge clk) begin
    rst_d <= rst;
    for (int b = 0; b < 4; b++) begin
      if (dmem_we[b]) begin
        dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  a_reset: assert property (@(posedge clk) rst_d |-> pc == 0 && dmem_we == 0)
    else begin
      errors++;
      $display("mismatch %s: expected pc 0 and we 0 in reset, actual pc %h, we %b",
               cur_name, $sampled(pc), $sampled(dmem_we));
    end

  a_store: assert property (@(posedge clk) disable iff (rst)
    cur_kind == 2'd1 |-> dmem_addr == {20'h0, store_base} && dmem_we == cur_we &&
      (dmem_wdata & cur_mask) == (cur_val & cur_mask))
    else begin
      errors++;
      $display("mismatch %s: expected addr %h we %b data %h, actual addr %h we %b data %h",
               cur_name, {20'h0, store_base}, $sampled(cur_we), $sampled(cur_val & cur_mask),
               $sampled(dmem_addr), $sampled(dmem_we), $sampled(dmem_wdata & cur_mask));
    end

  a_next_pc: assert property (@(posedge clk) disable iff (rst)
    cur_kind == 2'd2 |=> pc == $past(cur_val))
    else begin
      errors++;
      $display("mismatch %s: expected pc %h, actual pc %h", cur_name,
               $past(cur_val), $sampled(pc));
    end

  a_halt_raised: assert property (@(posedge clk) disable iff (rst)
    cur_kind == 2'd3 |-> halt && dmem_we == 0)
    else begin
      errors++;
      $display("%s: halt not raised on ecall at pc %h", cur_name, $sampled(pc));
    end

  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && pc == $past(pc) && dmem_we == 0)
    else begin
      errors++;
      $display("%s: core left the halted state at pc %h", cur_name, $sampled(pc));
    end

  function automatic rv_core_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg_reg};
  endfunction

  function automatic rv_core_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd,
                                               logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic rv_core_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_core_pkg::word_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  // expected alu value from the isa definition
  function automatic rv_core_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                                 rv_core_pkg::word_t a,
                                                 rv_core_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? rv_core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(logic [2:0] f3, rv_core_pkg::word_t a,
                                      rv_core_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(rv_core_pkg::word_t w);
    imem[wp] = w;
    wp++;
  endtask

  task automatic expect_at(logic [1:0] kind, rv_core_pkg::word_t val,
                           rv_core_pkg::strobe_t we);
    exp_kind[wp] = kind;
    exp_val[wp]  = val;
    exp_we[wp]   = we;
  endtask

  task automatic load_const(logic [4:0] rd, rv_core_pkg::word_t v);
    rv_core_pkg::word_t upper;
    upper = v + 32'h800;
    emit({upper[31:12], rd, rv_isa_pkg::op_lui});
    emit(enc_i(v[11:0], rd, rv_isa_pkg::f3_add_sub, rd, rv_isa_pkg::op_reg_imm));
  endtask

  // stores a register to 0x100 and checks the full word
  task automatic check_sw(logic [4:0] rs, rv_core_pkg::word_t val);
    expect_at(2'd1, val, 4'hf);
    emit(enc_s(store_base, rs, 5'd0, rv_isa_pkg::f3_sw));
  endtask

  task automatic begin_program(string name);
    @(posedge clk);
    #1;
    rst = 1'b1;
    cur_name = name;
    wp = 0;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = '0;
      exp_kind[i] = 2'd0;
      dmem[i] <= {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
    end
  endtask

  task automatic end_program();
    int errs_before;
    int n;
    errs_before = errors;
    expect_at(2'd3, '0, '0);
    emit(enc_i(12'h0, 5'd0, 3'd0, 5'd0, rv_isa_pkg::op_system));
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    n = 0;
    while (!halt && n < wp + 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!halt) begin
      errors++;
      $display("%s: core never reached the ecall", cur_name);
    end
    repeat (4) @(posedge clk);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s passed", cur_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_name, errors - errs_before);
    end
  endtask

  task automatic alu_rr_case(logic [2:0] f3, logic alt);
    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    a = $urandom;
    b = $urandom;
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(enc_r(alt ? rv_isa_pkg::funct7_alt : 7'd0, 5'd2, 5'd1, f3, 5'd3));
    check_sw(5'd3, ref_alu(f3, alt, a, b));
  endtask

  task automatic alu_ri_case(logic [2:0] f3, logic alt);
    rv_core_pkg::word_t a;
    logic [11:0]        imm;
    a = $urandom;
    imm = 12'($urandom);
    if (f3 == 3'd1 || f3 == 3'd5) begin
      imm = {alt ? rv_isa_pkg::funct7_alt : 7'd0, imm[4:0]};
    end
    load_const(5'd1, a);
    emit(enc_i(imm, 5'd1, f3, 5'd3, rv_isa_pkg::op_reg_imm));
    check_sw(5'd3, ref_alu(f3, alt, a, {{20{imm[11]}}, imm}));
  endtask

  task automatic branch_case(logic [2:0] f3, rv_core_pkg::word_t a, rv_core_pkg::word_t b);
    load_const(5'd1, a);
    load_const(5'd2, b);
    expect_at(2'd2, wp * 4 + (ref_branch(f3, a, b) ? 8 : 4), '0);
    emit(enc_b(13'd8, 5'd2, 5'd1, f3));
    // skipped slot when taken
    emit(enc_i(12'h0, 5'd0, 3'd0, 5'd0, rv_isa_pkg::op_reg_imm));
  endtask

  task automatic load_case(logic [2:0] f3, logic [1:0] off, rv_core_pkg::word_t val);
    emit(enc_i(12'h200 + off, 5'd0, f3, 5'd3, rv_isa_pkg::op_load));
    check_sw(5'd3, val);
  endtask

  // watchdog
  initial begin
    #(n_tests * test_cycles * 4 + 200);
    $display("watchdog expired, run did not complete");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [2:0]         br_f3 [6];
    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    rv_core_pkg::word_t w;
    logic [19:0]        u;
    int                 pc_at;
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    void'($urandom(32'h0ab415c1));

    begin_program("reset");
    end_program();

    begin_program("alu_reg_reg");
    for (int f = 0; f < 8; f++) begin
      alu_rr_case(3'(f), 1'b0);
      if (f == 0 || f == 5) alu_rr_case(3'(f), 1'b1);
    end
    end_program();

    begin_program("alu_reg_imm");
    for (int f = 0; f < 8; f++) begin
      alu_ri_case(3'(f), 1'b0);
      if (f == 5) alu_ri_case(3'(f), 1'b1);
    end
    end_program();

    begin_program("control_flow");
    for (int k = 0; k < 6; k++) begin
      a = $urandom;
      b = $urandom;
      branch_case(br_f3[k], a, b);
      branch_case(br_f3[k], b, a);
      branch_case(br_f3[k], a, a);
    end
    pc_at = wp * 4;
    expect_at(2'd2, pc_at + 12, '0);
    emit(enc_j(21'd12, 5'd5));
    wp += 2;
    check_sw(5'd5, pc_at + 4);
    pc_at = (wp + 2) * 4;
    // odd target so the core must clear bit 0
    load_const(5'd6, (pc_at + 12) | 1);
    expect_at(2'd2, pc_at + 12, '0);
    emit(enc_i(12'h0, 5'd6, 3'd0, 5'd7, rv_isa_pkg::op_jalr));
    wp += 2;
    check_sw(5'd7, pc_at + 4);
    u = 20'($urandom);
    emit({u, 5'd8, rv_isa_pkg::op_lui});
    check_sw(5'd8, {u, 12'h0});
    u = 20'($urandom);
    pc_at = wp * 4;
    emit({u, 5'd9, rv_isa_pkg::op_auipc});
    check_sw(5'd9, pc_at + {u, 12'h0});
    end_program();

    begin_program("sub_word_store");
    w = $urandom;
    load_const(5'd1, w);
    for (int k = 0; k < 4; k++) begin
      expect_at(2'd1, {24'h0, w[7:0]} << (8 * k), 4'b0001 << k);
      emit(enc_s(store_base + 12'(k), 5'd1, 5'd0, rv_isa_pkg::f3_sb));
    end
    expect_at(2'd1, {16'h0, w[15:0]}, 4'b0011);
    emit(enc_s(store_base, 5'd1, 5'd0, rv_isa_pkg::f3_sh));
    expect_at(2'd1, {w[15:0], 16'h0}, 4'b1100);
    emit(enc_s(store_base + 12'd2, 5'd1, 5'd0, rv_isa_pkg::f3_sh));
    end_program();

    begin_program("sub_word_load");
    // top bit set in bytes 0 and 3 and in the high half only
    w = 32'hf2347f81;
    dmem[128] <= w;
    for (int k = 0; k < 4; k++) begin
      load_case(rv_isa_pkg::f3_lb, 2'(k), {{24{w[8*k+7]}}, w[8*k +: 8]});
      load_case(rv_isa_pkg::f3_lbu, 2'(k), {24'h0, w[8*k +: 8]});
    end
    for (int k = 0; k < 4; k += 2) begin
      load_case(rv_isa_pkg::f3_lh, 2'(k), {{16{w[8*k+15]}}, w[8*k +: 16]});
      load_case(rv_isa_pkg::f3_lhu, 2'(k), {16'h0, w[8*k +: 16]});
    end
    load_case(rv_isa_pkg::f3_lw, 2'd0, w);
    end_program();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 halt,
  output rv_core_pkg::word_t   pc,
  input  rv_core_pkg::word_t   insn,
  output rv_core_pkg::word_t   dmem_addr,
  input  rv_core_pkg::word_t   dmem_rdata,
  output rv_core_pkg::word_t   dmem_wdata,
  output rv_core_pkg::strobe_t dmem_we
);

  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t result;
  rv_core_pkg::word_t store_src;
  rv_core_pkg::word_t rd_data;
  logic               rf_we;

  decode_if dec_bus ();

  instr_decoder i_decoder (
    .insn (insn),
    .dec  (dec_bus.decoder)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (dec_bus.rd),
    .rd_data  (rd_data),
    .rs1      (dec_bus.rs1),
    .rs2      (dec_bus.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit i_exec (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec_bus.exec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .result    (result),
    .store_src (store_src),
    .halt      (halt)
  );

  load_store_unit i_lsu (
    .dec        (dec_bus.lsu),
    .result     (result),
    .store_src  (store_src),
    .halt       (halt),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .rd_data    (rd_data),
    .rf_we      (rf_we)
  );

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/100ps

module load_store_unit (
  decode_if.lsu                dec,
  input  rv_core_pkg::word_t   result,
  input  rv_core_pkg::word_t   store_src,
  input  logic                 halt,
  output rv_core_pkg::word_t   dmem_addr,
  output rv_core_pkg::word_t   dmem_wdata,
  output rv_core_pkg::strobe_t dmem_we,
  input  rv_core_pkg::word_t   dmem_rdata,
  output rv_core_pkg::word_t   rd_data,
  output logic                 rf_we
);

  logic [1:0]           byte_off;
  logic [4:0]           lane_shift;
  rv_core_pkg::word_t   lane;
  rv_core_pkg::word_t   load_word;
  rv_core_pkg::strobe_t strobe;

  assign byte_off   = result[1:0];
  assign lane_shift = {byte_off, 3'b000};
  assign dmem_addr  = {result[31:2], 2'b00};

  // place the stored byte or half at its lane
  always_comb begin
    case (dec.funct3)
      rv_isa_pkg::f3_sb: begin
        strobe     = 4'b0001 << byte_off;
        dmem_wdata = {24'b0, store_src[7:0]} << lane_shift;
      end
      rv_isa_pkg::f3_sh: begin
        strobe     = byte_off[1] ? 4'b1100 : 4'b0011;
        dmem_wdata = {16'b0, store_src[15:0]} << {byte_off[1], 4'b0000};
      end
      rv_isa_pkg::f3_sw: begin
        strobe     = 4'b1111;
        dmem_wdata = store_src;
      end
      default: begin
        strobe     = 4'b0000;
        dmem_wdata = store_src;
      end
    endcase
  end

  assign dmem_we = dec.is_store ? strobe : '0;

  // addressed lane moved down to bit 0
  assign lane = dmem_rdata >> lane_shift;

  always_comb begin
    case (dec.funct3)
      rv_isa_pkg::f3_lb:  load_word = {{24{lane[7]}}, lane[7:0]};
      rv_isa_pkg::f3_lh:  load_word = {{16{lane[15]}}, lane[15:0]};
      rv_isa_pkg::f3_lw:  load_word = dmem_rdata;
      rv_isa_pkg::f3_lbu: load_word = {24'b0, lane[7:0]};
      rv_isa_pkg::f3_lhu: load_word = {16'b0, lane[15:0]};
      default:            load_word = dmem_rdata;
    endcase
  end

  assign rd_data = dec.is_load ? load_word : result;
  // no writeback while halted or to x0
  assign rf_we   = dec.reg_write && !halt && dec.rd != '0;

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit (
  input  logic               clk,
  input  logic               rst,
  decode_if.exec             dec,
  input  rv_core_pkg::word_t rs1_data,
  input  rv_core_pkg::word_t rs2_data,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t result,
  output rv_core_pkg::word_t store_src,
  output logic               halt
);

  rv_core_pkg::word_t pc_q;
  rv_core_pkg::word_t pc_next;
  rv_core_pkg::word_t pc_plus_step;
  rv_core_pkg::word_t target;
  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_out;
  logic [4:0]         shamt;
  logic               taken;

  // operand muxing
  assign op_a  = dec.use_pc ? pc_q : rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_core_pkg::alu_add:  alu_out = op_a + op_b;
      rv_core_pkg::alu_sub:  alu_out = op_a - op_b;
      rv_core_pkg::alu_sll:  alu_out = op_a << shamt;
      rv_core_pkg::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::alu_sltu: alu_out = {31'b0, op_a < op_b};
      rv_core_pkg::alu_xor:  alu_out = op_a ^ op_b;
      rv_core_pkg::alu_srl:  alu_out = op_a >> shamt;
      rv_core_pkg::alu_sra:  alu_out = rv_core_pkg::word_t'($signed(op_a) >>> shamt);
      rv_core_pkg::alu_or:   alu_out = op_a | op_b;
      rv_core_pkg::alu_and:  alu_out = op_a & op_b;
      default:               alu_out = op_b;
    endcase
  end

  // branch conditions compare the registers directly
  always_comb begin
    case (dec.funct3)
      rv_isa_pkg::f3_beq:  taken = rs1_data == rs2_data;
      rv_isa_pkg::f3_bne:  taken = rs1_data != rs2_data;
      rv_isa_pkg::f3_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_isa_pkg::f3_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_isa_pkg::f3_bltu: taken = rs1_data < rs2_data;
      rv_isa_pkg::f3_bgeu: taken = rs1_data >= rs2_data;
      default:             taken = 1'b0;
    endcase
  end

  assign pc_plus_step = pc_q + rv_core_pkg::word_t'(rv_core_pkg::pc_step);
  assign target       = pc_q + dec.imm;
  assign halt         = dec.is_ecall;

  always_comb begin
    if (halt) begin
      pc_next = pc_q;
    end else if (dec.is_jalr) begin
      // target lsb is always cleared
      pc_next = {alu_out[31:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  // jumps link the return address
  assign result    = (dec.is_jal || dec.is_jalr) ? pc_plus_step : alu_out;
  assign store_src = rs2_data;
  assign pc        = pc_q;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  rv_core_pkg::reg_idx_t rd,
  input  rv_core_pkg::word_t    rd_data,
  input  rv_core_pkg::reg_idx_t rs1,
  input  rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::word_t    rs1_data,
  output rv_core_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // asynchronous reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
  input rv_isa_pkg::instr_t insn,
  decode_if.decoder         dec
);

  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_b;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;
  logic               alt;

  // map funct3 (plus the alt bit) onto an alu operation
  function automatic rv_core_pkg::alu_op_t alu_from_f3(logic [2:0] f3, logic sub_sra);
    rv_core_pkg::alu_op_t op;
    case (f3)
      rv_isa_pkg::f3_add_sub: op = sub_sra ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_isa_pkg::f3_sll:     op = rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     op = rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    op = rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     op = rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_sra_srl: op = sub_sra ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:      op = rv_core_pkg::alu_or;
      default:                op = rv_core_pkg::alu_and;
    endcase
    return op;
  endfunction

  // sign-extended immediates, one per format
  assign imm_i = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
  assign imm_s = {{20{insn.s_fmt.imm_11_5[6]}}, insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};
  assign imm_b = {{20{insn.b_fmt.imm_12}}, insn.b_fmt.imm_11, insn.b_fmt.imm_10_5,
                  insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{12{insn.j_fmt.imm_20}}, insn.j_fmt.imm_19_12, insn.j_fmt.imm_11,
                  insn.j_fmt.imm_10_1, 1'b0};

  assign alt = insn.r_fmt.funct7 == rv_isa_pkg::funct7_alt;

  assign dec.rs1    = insn.r_fmt.rs1;
  assign dec.rs2    = insn.r_fmt.rs2;
  assign dec.rd     = insn.r_fmt.rd;
  assign dec.funct3 = insn.r_fmt.funct3;

  always_comb begin
    // defaults leave an unknown opcode doing nothing
    dec.imm       = imm_i;
    dec.alu_op    = rv_core_pkg::alu_add;
    dec.use_imm   = 1'b0;
    dec.use_pc    = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.is_ecall  = 1'b0;
    dec.reg_write = 1'b0;
    case (insn.r_fmt.opcode)
      rv_isa_pkg::op_lui: begin
        dec.imm       = imm_u;
        dec.alu_op    = rv_core_pkg::alu_pass_b;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.use_pc    = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        dec.imm       = imm_j;
        dec.is_jal    = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        // alu forms rs1 + imm as the target
        dec.use_imm   = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      rv_isa_pkg::op_load: begin
        dec.use_imm   = 1'b1;
        dec.is_load   = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      rv_isa_pkg::op_reg_imm: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        // only srai uses the alt bit, addi never means sub
        dec.alu_op    = alu_from_f3(insn.i_fmt.funct3,
                                    alt && insn.i_fmt.funct3 == rv_isa_pkg::f3_sra_srl);
        if (insn.i_fmt.funct3 == rv_isa_pkg::f3_sll ||
            insn.i_fmt.funct3 == rv_isa_pkg::f3_sra_srl) begin
          dec.imm = {27'b0, insn.r_fmt.rs2};
        end
      end
      rv_isa_pkg::op_reg_reg: begin
        dec.alu_op    = alu_from_f3(insn.r_fmt.funct3, alt);
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::op_system: begin
        // ecall only; every other field must be zero
        dec.is_ecall = insn.i_fmt.imm_11_0 == '0 && insn.i_fmt.rs1 == '0 &&
                       insn.i_fmt.funct3 == '0 && insn.i_fmt.rd == '0;
      end
      default: begin
        dec.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;
  rv_core_pkg::reg_idx_t rs1;
  rv_core_pkg::reg_idx_t rs2;
  rv_core_pkg::reg_idx_t rd;
  rv_core_pkg::word_t    imm;
  rv_core_pkg::alu_op_t  alu_op;
  logic                  use_imm;
  logic                  use_pc;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;
  logic                  is_load;
  logic                  is_store;
  logic                  is_ecall;
  logic [2:0]            funct3;
  logic                  reg_write;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, use_imm, use_pc, is_branch, is_jal,
    output is_jalr, is_load, is_store, is_ecall, funct3, reg_write
  );

  modport exec (
    input imm, alu_op, use_imm, use_pc, is_branch, is_jal, is_jalr, funct3, is_ecall
  );

  modport lsu (
    input is_load, is_store, funct3, rd, reg_write
  );
endinterface

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int unsigned xlen = 32;

  // bytes per instruction
  localparam int unsigned pc_step = 4;

  typedef logic [4:0] reg_idx_t;
  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen/8-1:0] strobe_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui just forwards the immediate
    alu_pass_b
  } alu_op_t;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_system  = 7'b1110011;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_lui     = 7'b0110111;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load and store widths
  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sh  = 3'b001;
  localparam logic [2:0] f3_sw  = 3'b010;

  // alu operations, shared by reg-imm and reg-reg
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_sra_srl = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // selects sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, read through every format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage
